/* source/dht_settings.svh */
`ifndef DHT_SETTINGS_SVH
`define DHT_SETTINGS_SVH

// Cycles that sensor_start stays high
`define DHT_START_CYCLES 20

// High phase longer than this is a 1 bit
`define DHT_BIT_THRESHOLD 6

// High phase longer than this is a protocol fault
`define DHT_PULSE_LIMIT 16

// Cycles allowed for both frames of one attempt
`define DHT_TIMEOUT_CYCLES 600

`define DHT_MAX_TRIES 3

`endif

/* source/dht_sensor_pkg.sv */
`default_nettype none

package dht_sensor_pkg;

  // One measurement value from the sensor
  typedef logic [7:0] reading_t;

  // 8 data bits followed by one even-parity bit
  localparam int FRAME_BITS = 9;

endpackage

`default_nettype wire

/* source/dht_control_pkg.sv */
`default_nettype none

package dht_control_pkg;

  typedef enum logic [3:0] {
    idle              = 4'd0,
    start             = 4'd1,
    wait_start        = 4'd2,  // sensor_start held high
    wait_temperature  = 4'd3,
    store_temperature = 4'd4,
    wait_humidity     = 4'd5,
    store_humidity    = 4'd6,
    done              = 4'd7,
    attempt_failed    = 4'd8,
    final_error       = 4'd9
  } measure_state_t;

endpackage

`default_nettype wire

/* source/dht11_control_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dht11_control_if;

  // Commands from the control unit
  logic clear_tries;
  logic count_tries;
  logic clear_timeout;
  logic count_timeout;
  logic count_start;
  logic load_temperature;
  logic load_humidity;

  // Conditions from the datapath
  logic start_done;
  logic frame_ok;
  logic frame_done;
  logic timeout;
  logic tries_done;

  modport control (
    output clear_tries, count_tries, clear_timeout, count_timeout,
    output count_start, load_temperature, load_humidity,
    input  start_done, frame_ok, frame_done, timeout, tries_done
  );

  modport datapath (
    input  clear_tries, count_tries, clear_timeout, count_timeout,
    input  count_start, load_temperature, load_humidity,
    output start_done, frame_ok, frame_done, timeout, tries_done
  );

endinterface

`default_nettype wire

/* source/event_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module event_counter #(
  parameter int WIDTH = 8,
  parameter int LIMIT = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic enable,
  output logic last
);

  logic [WIDTH-1:0] count;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (enable && !last) begin
      count <= count + 1'b1;  // Holds once the limit is reached
    end
  end

  assign last = (count == WIDTH'(LIMIT - 1));

endmodule

`default_nettype wire

/* source/pulse_receiver.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dht_settings.svh"

module pulse_receiver
  import dht_sensor_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     clear,
  input  logic     enable,
  input  logic     sensor_data,
  output reading_t frame,
  output logic     frame_done,
  output logic     frame_ok
);

  localparam int HIGH_WIDTH  = $clog2(`DHT_PULSE_LIMIT + 2);
  localparam int COUNT_WIDTH = $clog2(FRAME_BITS);

  logic                   data_meta;
  logic                   data_sync;
  logic                   data_prev;
  logic                   falling;
  logic                   bit_value;
  logic                   last_bit;
  logic                   overlong;
  logic [HIGH_WIDTH-1:0]  high_count;
  logic [COUNT_WIDTH-1:0] bit_count;
  logic [FRAME_BITS-2:0]  data_bits;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      data_meta <= 1'b0;
      data_sync <= 1'b0;
      data_prev <= 1'b0;
    end else begin
      data_meta <= sensor_data;
      data_sync <= data_meta;
      data_prev <= data_sync;
    end
  end

  assign falling   = enable && data_prev && !data_sync;  // End of a bit
  assign bit_value = (high_count > HIGH_WIDTH'(`DHT_BIT_THRESHOLD));
  assign last_bit  = (bit_count == COUNT_WIDTH'(FRAME_BITS - 1));
  assign overlong  = enable && data_sync && (high_count >= HIGH_WIDTH'(`DHT_PULSE_LIMIT));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      high_count <= '0;
      bit_count  <= '0;
      frame_done <= 1'b0;
      frame_ok   <= 1'b1;
    end else if (clear) begin
      high_count <= '0;
      bit_count  <= '0;
      frame_done <= 1'b0;
      frame_ok   <= 1'b1;
    end else begin
      frame_done <= falling && last_bit;
      if (overlong) begin
        frame_ok <= 1'b0;
      end
      if (falling || !data_sync) begin
        high_count <= '0;
      end else if (enable && !overlong) begin
        high_count <= high_count + 1'b1;
      end
      if (falling) begin
        if (last_bit) begin
          bit_count <= '0;
          if (^{data_bits, bit_value}) begin
            frame_ok <= 1'b0;  // Odd number of ones
          end
        end else begin
          bit_count <= bit_count + 1'b1;
        end
      end
    end
  end

  // MSB arrives first; parity bit is shifted in but never captured
  always_ff @(posedge clock) begin
    if (falling) begin
      data_bits <= {data_bits[FRAME_BITS-3:0], bit_value};
      if (last_bit) begin
        frame <= data_bits;
      end
    end
  end

endmodule

`default_nettype wire

/* source/dht11_control.sv */
`timescale 1ns/1ns
`default_nettype none

module dht11_control
  import dht_control_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             measure,
  dht11_control_if.control bus,
  output logic             sensor_start,
  output logic             ready,
  output logic             error,
  output measure_state_t   debug_state
);

  measure_state_t state;
  measure_state_t state_next;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (measure) begin
          state_next = start;
        end
      end
      start:             state_next = wait_start;
      wait_start: begin
        if (bus.start_done) begin
          state_next = wait_temperature;
        end
      end
      wait_temperature: begin
        if (!bus.frame_ok || bus.timeout) begin
          state_next = attempt_failed;
        end else if (bus.frame_done) begin
          state_next = store_temperature;
        end
      end
      store_temperature: state_next = wait_humidity;
      wait_humidity: begin
        if (!bus.frame_ok || bus.timeout) begin
          state_next = attempt_failed;
        end else if (bus.frame_done) begin
          state_next = store_humidity;
        end
      end
      store_humidity:    state_next = done;
      done:              state_next = idle;
      attempt_failed:    state_next = bus.tries_done ? final_error : start;  // Retry
      final_error:       state_next = idle;
      default:           state_next = idle;
    endcase
  end

  assign bus.clear_tries      = (state == idle);
  assign bus.count_tries      = (state == attempt_failed);
  assign bus.clear_timeout    = (state == start);
  assign bus.count_timeout    = (state == wait_temperature) || (state == wait_humidity);
  assign bus.count_start      = (state == wait_start);
  assign bus.load_temperature = (state == store_temperature);
  assign bus.load_humidity    = (state == store_humidity);

  assign sensor_start = (state == wait_start);
  assign ready        = (state == done);
  assign error        = (state == final_error);
  assign debug_state  = state;

endmodule

`default_nettype wire

/* source/dht11_datapath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dht_settings.svh"

module dht11_datapath
  import dht_sensor_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  dht11_control_if.datapath bus,
  input  logic              sensor_data,
  output reading_t          temperature,
  output reading_t          humidity
);

  localparam int START_WIDTH   = $clog2(`DHT_START_CYCLES);
  localparam int TIMEOUT_WIDTH = $clog2(`DHT_TIMEOUT_CYCLES);
  localparam int TRIES_WIDTH   = $clog2(`DHT_MAX_TRIES);

  reading_t frame;

  event_counter #(.WIDTH(START_WIDTH), .LIMIT(`DHT_START_CYCLES)) u_start_counter (
    .clock  (clock),
    .reset  (reset),
    .clear  (!bus.count_start),  // Restarts on every entry to wait_start
    .enable (bus.count_start),
    .last   (bus.start_done)
  );

  event_counter #(.WIDTH(TIMEOUT_WIDTH), .LIMIT(`DHT_TIMEOUT_CYCLES)) u_timeout_counter (
    .clock  (clock),
    .reset  (reset),
    .clear  (bus.clear_timeout),
    .enable (bus.count_timeout),
    .last   (bus.timeout)
  );

  event_counter #(.WIDTH(TRIES_WIDTH), .LIMIT(`DHT_MAX_TRIES)) u_tries_counter (
    .clock  (clock),
    .reset  (reset),
    .clear  (bus.clear_tries),
    .enable (bus.count_tries),
    .last   (bus.tries_done)
  );

  pulse_receiver u_pulse_receiver (
    .clock       (clock),
    .reset       (reset),
    .clear       (bus.clear_timeout),
    .enable      (bus.count_timeout),
    .sensor_data (sensor_data),
    .frame       (frame),
    .frame_done  (bus.frame_done),
    .frame_ok    (bus.frame_ok)
  );

  // Readings only change in the store states
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      temperature <= '0;
      humidity    <= '0;
    end else begin
      if (bus.load_temperature) begin
        temperature <= frame;
      end
      if (bus.load_humidity) begin
        humidity <= frame;
      end
    end
  end

endmodule

`default_nettype wire

/* source/dht11_interface.sv */
`timescale 1ns/1ns
`default_nettype none

module dht11_interface (
  input  logic       clock,
  input  logic       reset,
  input  logic       measure,
  input  logic       sensor_data,
  output logic       sensor_start,
  output logic       ready,
  output logic       error,
  output logic [7:0] temperature,
  output logic [7:0] humidity,
  output logic [3:0] debug_state
);

  dht11_control_if bus ();

  dht11_control u_dht11_control (
    .clock        (clock),
    .reset        (reset),
    .measure      (measure),
    .bus          (bus.control),
    .sensor_start (sensor_start),
    .ready        (ready),
    .error        (error),
    .debug_state  (debug_state)
  );

  dht11_datapath u_dht11_datapath (
    .clock       (clock),
    .reset       (reset),
    .bus         (bus.datapath),
    .sensor_data (sensor_data),
    .temperature (temperature),
    .humidity    (humidity)
  );

endmodule

`default_nettype wire

/* verification/dht11_checker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dht_settings.svh"

module dht11_checker
  import dht_control_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         sensor_start,
  input  logic         ready,
  input  logic         error,
  input  logic [7:0]   temperature,
  input  logic [7:0]   humidity,
  input  logic [3:0]   debug_state,
  input  logic         test_start,
  input  logic [127:0] test_name,
  input  logic         expect_ready,
  input  logic [7:0]   expect_temperature,
  input  logic [7:0]   expect_humidity,
  input  logic [3:0]   expect_starts,
  output logic         test_done,
  output logic         timed_out,
  output logic [15:0]  passed,
  output logic [15:0]  failed
);

  localparam int RESULT_LIMIT =
    `DHT_MAX_TRIES * (`DHT_START_CYCLES + `DHT_TIMEOUT_CYCLES + 20) + 200;

  logic active;
  logic start_prev;
  int   high_length;
  int   start_count;
  int   test_errors;
  int   wait_cycles;

  initial begin
    active      = 1'b0;
    start_prev  = 1'b0;
    high_length = 0;
    start_count = 0;
    test_errors = 0;
    wait_cycles = 0;
    test_done   = 1'b0;
    timed_out   = 1'b0;
    passed      = '0;
    failed      = '0;
  end

  task automatic compare_value(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, got);
      test_errors++;
    end
  endtask

  task automatic finish_test();
    compare_value("ready", ready, expect_ready);
    compare_value("error", error, !expect_ready);
    compare_value("debug_state", debug_state, expect_ready ? done : final_error);
    compare_value("temperature", temperature, expect_temperature);
    compare_value("humidity", humidity, expect_humidity);
    compare_value("sensor_start pulses", start_count, expect_starts);
    if (test_errors == 0) begin
      passed = passed + 1'b1;
      $display("Test %0s: passed", test_name);
    end else begin
      failed = failed + 1'b1;
      $display("Test %0s: failed with %0d errors", test_name, test_errors);
    end
    active    = 1'b0;
    test_done = 1'b1;
  endtask

  // Outputs are decoded from registers, so the falling edge sees them settled
  always @(negedge clock) begin
    if (reset) begin
      start_prev  = 1'b0;
      high_length = 0;
    end else begin
      if (test_start) begin
        active      = 1'b1;
        test_done   = 1'b0;
        start_count = 0;
        test_errors = 0;
        wait_cycles = 0;
        compare_value("debug_state", debug_state, idle);  // Strobe arrives in idle
      end
      if (sensor_start) begin
        high_length++;
      end else if (start_prev) begin
        start_count++;
        compare_value("sensor_start length", high_length, `DHT_START_CYCLES);
        high_length = 0;
      end
      start_prev = sensor_start;
      if (ready || error) begin
        if (active) begin
          finish_test();
        end else begin
          $display("Ready or error pulse seen while no test was running");
          failed = failed + 1'b1;
        end
      end else if (active) begin
        wait_cycles++;
        if (wait_cycles > RESULT_LIMIT) begin
          $display("Test %0s: no ready or error pulse within %0d cycles", test_name, RESULT_LIMIT);
          failed    = failed + 1'b1;
          active    = 1'b0;
          timed_out = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/dht11_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dht_settings.svh"

module dht11_tb;

  localparam int RESULT_LIMIT = 3000;
  localparam int RISE_LIMIT   = 2 * `DHT_TIMEOUT_CYCLES;  // Covers a silent attempt
  localparam int RETRY_LIMIT  = 10;  // Parity and pulse faults end an attempt early

  logic         clock;
  logic         reset;
  logic         measure;
  logic         sensor_data;
  logic         sensor_start;
  logic         ready;
  logic         error;
  logic [7:0]   temperature;
  logic [7:0]   humidity;
  logic [3:0]   debug_state;
  logic         test_start;
  logic [127:0] test_name;
  logic         expect_ready;
  logic [7:0]   expect_temperature;
  logic [7:0]   expect_humidity;
  logic [3:0]   expect_starts;
  logic         test_done;
  logic         timed_out;
  logic [15:0]  passed;
  logic [15:0]  failed;
  logic [31:0]  rng_state;
  logic         hang;
  int           fault_codes [0:2];

  dht11_interface u_dht11_interface (
    .clock        (clock),
    .reset        (reset),
    .measure      (measure),
    .sensor_data  (sensor_data),
    .sensor_start (sensor_start),
    .ready        (ready),
    .error        (error),
    .temperature  (temperature),
    .humidity     (humidity),
    .debug_state  (debug_state)
  );

  dht11_checker u_dht11_checker (
    .clock              (clock),
    .reset              (reset),
    .sensor_start       (sensor_start),
    .ready              (ready),
    .error              (error),
    .temperature        (temperature),
    .humidity           (humidity),
    .debug_state        (debug_state),
    .test_start         (test_start),
    .test_name          (test_name),
    .expect_ready       (expect_ready),
    .expect_temperature (expect_temperature),
    .expect_humidity    (expect_humidity),
    .expect_starts      (expect_starts),
    .test_done          (test_done),
    .timed_out          (timed_out),
    .passed             (passed),
    .failed             (failed)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Attempts until the first good one, or all of them
  function automatic logic [3:0] count_attempts();
    int n;
    n = `DHT_MAX_TRIES;
    for (int i = `DHT_MAX_TRIES - 1; i >= 0; i--) begin
      if (fault_codes[i] == 0) begin
        n = i + 1;
      end
    end
    return n[3:0];
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #5;
  endtask

  task automatic send_bit(input logic value);
    rng_state = xorshift(rng_state);
    sensor_data = 1'b0;
    repeat (1 + rng_state % 3) next_cycle();
    sensor_data = 1'b1;
    repeat (value ? 10 : 3) next_cycle();
    sensor_data = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] value, input logic bad_parity);
    for (int i = 7; i >= 0; i--) begin
      send_bit(value[i]);
    end
    send_bit(^value ^ bad_parity);  // Even parity unless corrupted
    repeat (4) next_cycle();
  endtask

  task automatic send_overlong();
    sensor_data = 1'b0;
    next_cycle();
    sensor_data = 1'b1;
    repeat (`DHT_PULSE_LIMIT + 4) next_cycle();
    sensor_data = 1'b0;
  endtask

  task automatic wait_start_pulse(input int rise_limit, output logic seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!sensor_start && cycles < rise_limit) begin
      next_cycle();
      cycles++;
    end
    if (sensor_start) begin
      cycles = 0;
      while (sensor_start && cycles < `DHT_START_CYCLES + 10) begin
        next_cycle();
        cycles++;
      end
      seen = !sensor_start;
    end
    if (!seen) begin
      $display("Timeout: no complete sensor_start pulse within %0d cycles", rise_limit);
    end
  endtask

  task automatic emulate_sensor(input logic [7:0] temp_value, input logic [7:0] hum_value);
    int   attempt;
    int   rise_limit;
    logic seen;
    logic finished;
    attempt = 0;
    rise_limit = RISE_LIMIT;
    finished = 1'b0;
    while (attempt < `DHT_MAX_TRIES && !finished) begin
      wait_start_pulse(rise_limit, seen);
      if (!seen) begin
        hang = 1'b1;
        finished = 1'b1;
      end else begin
        rise_limit = RISE_LIMIT;
        case (fault_codes[attempt])
          0: begin
            send_frame(temp_value, 1'b0);
            send_frame(hum_value, 1'b0);
            finished = 1'b1;
          end
          1: begin
            send_frame(temp_value, 1'b1);
            rise_limit = RETRY_LIMIT;
          end
          3: begin
            send_overlong();
            rise_limit = RETRY_LIMIT;
          end
          default: ;  // Silent sensor
        endcase
      end
      attempt++;
    end
  endtask

  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (!test_done && !timed_out && cycles < RESULT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (!test_done) begin
      hang = 1'b1;
      if (cycles >= RESULT_LIMIT) begin
        $display("Timeout: the checker did not finish test %0s", test_name);
      end
    end
  endtask

  initial begin
    int                 fd;
    int                 fields;
    int                 t_val;
    int                 h_val;
    logic [8*100-1:0]   line;
    logic [63:0]        outcome;
    logic [7:0]         last_temperature;
    logic [7:0]         last_humidity;
    reset = 1'b1;
    measure = 1'b0;
    sensor_data = 1'b0;
    test_start = 1'b0;
    test_name = '0;
    expect_ready = 1'b0;
    expect_temperature = '0;
    expect_humidity = '0;
    expect_starts = '0;
    rng_state = 32'h6e0d495d;
    hang = 1'b0;
    last_temperature = '0;
    last_humidity = '0;
    repeat (3) next_cycle();
    reset = 1'b0;
    fd = $fopen("verification/dht11_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file");
      hang = 1'b1;
    end else begin
      while (!hang && !$feof(fd)) begin
        line = '0;
        fields = $fgets(line, fd);
        fields = $sscanf(line, "%s %h %h %d %d %d %s", test_name, t_val, h_val,
                         fault_codes[0], fault_codes[1], fault_codes[2], outcome);
        if (fields == 7) begin
          expect_ready = (outcome == "ready");
          if (expect_ready) begin
            last_temperature = t_val[7:0];
            last_humidity = h_val[7:0];
          end
          expect_temperature = last_temperature;  // Held over after an error
          expect_humidity = last_humidity;
          expect_starts = count_attempts();
          measure = 1'b1;
          test_start = 1'b1;
          next_cycle();
          measure = 1'b0;
          test_start = 1'b0;
          fork
            emulate_sensor(t_val[7:0], h_val[7:0]);
            begin
              repeat (5) next_cycle();
              measure = 1'b1;  // Lands in wait_start and must be ignored
              next_cycle();
              measure = 1'b0;
              wait_result();
            end
          join
          repeat (5) next_cycle();
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
    if (hang || failed != 0 || passed == 0) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+source
source/dht_sensor_pkg.sv
source/dht_control_pkg.sv
source/dht11_control_if.sv
source/event_counter.sv
source/pulse_receiver.sv
source/dht11_control.sv
source/dht11_datapath.sv
source/dht11_interface.sv
verification/dht11_checker.sv
verification/dht11_tb.sv

/* verification/dht11_patterns.txt */
# name temperature(hex) humidity(hex) fault1 fault2 fault3 outcome
# Per-attempt fault codes: 0 good, 1 temperature parity, 2 silent, 3 overlong pulse
good_first     17 3c 0 0 0 ready
zero_and_full  00 ff 0 0 0 ready
parity_retry   1a 2d 1 0 0 ready
overlong_retry 22 48 3 0 0 ready
silent_all     55 66 2 2 2 error
mixed_third    0f 5a 1 3 0 ready
silent_then_ok 2b 71 2 0 0 ready
all_faults     a5 5a 3 1 2 error
pattern_mix    96 c3 0 2 1 ready
